//--- vlog.f
hdl/pe_cfg_pkg.sv
hdl/pe_data_pkg.sv
hdl/gbuf_shared.sv
hdl/spad_fetch.sv
hdl/pe_mac.sv
hdl/pe_top.sv
test/pe_asserts.sv
test/pe_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       := pe_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := TESTBENCH FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/pe_tb.sv
// ==============================
// random runs against a dot-product model, bases are random and wrap at 256
// ==============================
`timescale 1ns/1ps

module pe_tb;

    logic                 i_clk;
    logic                 i_rstn;
    logic                 i_start;
    pe_cfg_pkg::pe_cfg_t  i_cfg;
    logic                 i_gb_wr_en;
    pe_data_pkg::gb_wr_t  i_gb_wr;
    logic                 o_psum_valid;
    pe_data_pkg::psum_t   o_psum;
    logic                 i_psum_ready;
    logic                 o_busy;
    logic                 o_done;

    logic [15:0]        gb_img [256];   // mirror of the buffer
    pe_data_pkg::psum_t exp_q [$];
    pe_data_pkg::psum_t exp_head;
    int                 pend;
    int                 got_cnt;
    int                 done_cnt;
    logic               rdy_rand;

    pe_top dut0 (.*);

    always #20 i_clk = ~i_clk;

    task automatic stop_with_error(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout at %0t: %s never happened", $time, what);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped on timeout");
    endtask

    // ==============================
    // checks
    // ==============================
    a_psum: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_psum_valid && i_psum_ready |-> pend > 0 && o_psum == exp_head)
        else stop_with_error($sformatf("psum %0d, expected %0d",
                                       $sampled(o_psum), $sampled(exp_head)));

    a_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_psum_valid && !i_psum_ready |=> o_psum_valid && $stable(o_psum))
        else stop_with_error("psum changed or dropped before it was accepted");

    a_done: assert property (@(posedge i_clk) disable iff (!i_rstn)
        o_done |-> pend == 0 && !o_busy && !o_psum_valid)
        else stop_with_error("done while psums were still expected");

    // ready toggles on the falling edge
    always @(negedge i_clk) begin
        i_psum_ready = rdy_rand ? 1'($urandom % 2) : 1'b1;
    end

    // accepted psums leave the model queue
    always @(posedge i_clk) begin
        if (o_done) done_cnt++;
        if (o_psum_valid && i_psum_ready && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            got_cnt++;
            pend     = exp_q.size();
            exp_head = (pend != 0) ? exp_q[0] : '0;
        end
    end

    task automatic load_buffer(input int zero_pct);
        int i;
        for (i = 0; i < 256; i++) begin
            gb_img[i] = ($urandom % 100 < zero_pct) ? 16'h0000 : 16'($urandom);
            @(negedge i_clk);
            i_gb_wr_en   = 1'b1;
            i_gb_wr.addr = 8'(i);
            i_gb_wr.data = gb_img[i];
        end
        @(negedge i_clk);
        i_gb_wr_en = 1'b0;
    endtask

    // one run, optionally with a second start while busy
    task automatic run_once(input int taps, input int outs, input bit extra_start);
        pe_cfg_pkg::pe_cfg_t cfg;
        pe_data_pkg::psum_t  sum;
        logic [7:0]          a;
        logic [7:0]          w;
        int                  n;
        int                  k;
        int                  cyc;
        cfg.if_base = 8'($urandom);
        cfg.w_base  = 8'($urandom);
        cfg.taps    = 4'(taps);
        cfg.outs    = 6'(outs);
        for (n = 0; n < outs; n++) begin
            sum = '0;
            for (k = 0; k < taps; k++) begin
                a = cfg.if_base + 8'(n * taps + k);
                w = cfg.w_base + 8'(k);
                sum += $signed(gb_img[a]) * $signed(gb_img[w][7:0]);
            end
            exp_q.push_back(sum);
        end
        pend     = exp_q.size();
        exp_head = exp_q[0];
        got_cnt  = 0;
        done_cnt = 0;
        @(negedge i_clk);
        i_cfg   = cfg;
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        if (extra_start && outs >= 4) begin
            repeat (3) @(negedge i_clk);
            i_cfg   = pe_cfg_pkg::pe_cfg_t'($urandom);    // must be ignored
            i_start = 1'b1;
            @(negedge i_clk);
            i_start = 1'b0;
        end
        cyc = 0;
        while (done_cnt == 0) begin
            if (cyc == 5000) stop_on_timeout("o_done");
            @(negedge i_clk);
            cyc++;
        end
        repeat (2) @(negedge i_clk);
        assert (got_cnt == outs && done_cnt == 1)
            else stop_with_error($sformatf("%0d psums and %0d done pulses for %0d outputs",
                                           got_cnt, done_cnt, outs));
    endtask

    // ==============================
    // stimulus
    // ==============================
    initial begin
        int r;
        void'($urandom(32'hfcb18da1));
        i_clk        = 1'b0;
        i_rstn       = 1'b0;
        i_start      = 1'b0;
        i_cfg        = '0;
        i_gb_wr_en   = 1'b0;
        i_gb_wr      = '0;
        i_psum_ready = 1'b1;
        rdy_rand     = 1'b0;
        pend         = 0;
        got_cnt      = 0;
        done_cnt     = 0;
        exp_head     = '0;
        repeat (4) @(negedge i_clk);
        assert (!o_psum_valid && !o_busy && !o_done)
            else stop_with_error("control outputs high during reset");
        i_rstn = 1'b1;

        load_buffer(30);
        run_once(1, 1, 1'b0);
        run_once(pe_cfg_pkg::pad_depth, 8, 1'b0);
        rdy_rand = 1'b1;                        // back-pressure from here on
        run_once(1, 8, 1'b1);
        run_once(pe_cfg_pkg::pad_depth, 6, 1'b1);
        for (r = 0; r < 8; r++) begin
            run_once(1 + $urandom % pe_cfg_pkg::pad_depth, 1 + $urandom % 8, r[0]);
        end

        load_buffer(80);                        // mostly zero pixels
        run_once(pe_cfg_pkg::pad_depth, 8, 1'b1);
        for (r = 0; r < 4; r++) begin
            run_once(1 + $urandom % pe_cfg_pkg::pad_depth, 1 + $urandom % 8, 1'b0);
        end

        repeat (2) @(negedge i_clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- test/pe_asserts.sv
// ==============================
// bound to pe_top, reads its internal wires and the MAC enable
// ==============================
`timescale 1ns/1ps

module pe_asserts (
    input logic       i_clk,
    input logic       i_rstn,
    input logic       start_go,
    input logic [1:0] req_valid,
    input logic [1:0] grant,
    input logic [1:0] rsp_valid,
    input logic       if_valid,
    input logic       if_ready,
    input logic       wt_valid,
    input logic       wt_ready,
    input pe_data_pkg::if_pix_t if_head,
    input logic       mac_en,
    input logic       o_psum_valid,
    input logic       o_busy,
    input logic       o_done
);

    // ==============================
    // arbiter
    // ==============================
    a_one_grant: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $onehot0(grant) && (grant & ~req_valid) == 2'b00)
        else $error("more than one grant, or a grant without a request");

    // a waiting pad wins right after the other one
    a_rr_if: assert property (@(posedge i_clk) disable iff (!i_rstn)
        req_valid[0] && grant[1] |=> grant[0])
        else $error("ifmap pad not granted after the weight pad");

    a_rr_wt: assert property (@(posedge i_clk) disable iff (!i_rstn)
        req_valid[1] && grant[0] |=> grant[1])
        else $error("weight pad not granted after the ifmap pad");

    a_rsp: assert property (@(posedge i_clk) disable iff (!i_rstn)
        rsp_valid == $past(grant))
        else $error("response valid does not follow the grant by one cycle");

    // ==============================
    // pads and MAC
    // ==============================
    // zero bit set exactly for a zero word
    a_zero_flag: assert property (@(posedge i_clk) disable iff (!i_rstn)
        if_valid |-> if_head.zero == (if_head.data == '0))
        else $error("ifmap zero bit does not match the pixel");

    a_zero_skip: assert property (@(posedge i_clk) disable iff (!i_rstn)
        mac_en |-> !if_head.zero)
        else $error("multiplier enabled on a zero pixel");

    a_if_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
        if_valid && !if_ready && !start_go |=> if_valid)
        else $error("ifmap valid dropped without a transfer");

    a_wt_hold: assert property (@(posedge i_clk) disable iff (!i_rstn)
        wt_valid && !wt_ready && !start_go |=> wt_valid)
        else $error("weight valid dropped without a transfer");

    // control outputs while in reset
    a_reset: assert property (@(posedge i_clk)
        !i_rstn |-> !o_psum_valid && !o_busy && !o_done && req_valid == 2'b00
                    && !if_ready && !wt_ready)
        else $error("control output high during reset");

endmodule

bind pe_top pe_asserts u_asserts (
    .i_clk, .i_rstn, .start_go,
    .req_valid, .grant, .rsp_valid,
    .if_valid, .if_ready, .wt_valid, .wt_ready,
    .if_head, .mac_en(u_mac.mac_en),
    .o_psum_valid, .o_busy, .o_done
);

//--- hdl/pe_top.sv
// ==============================
// load the buffer before start, a start while busy is dropped
// ==============================
`timescale 1ns/1ps

module pe_top (
    input  logic                  i_clk,
    input  logic                  i_rstn,
    input  logic                  i_start,
    input  pe_cfg_pkg::pe_cfg_t   i_cfg,
    input  logic                  i_gb_wr_en,
    input  pe_data_pkg::gb_wr_t   i_gb_wr,
    output logic                  o_psum_valid,
    output pe_data_pkg::psum_t    o_psum,
    input  logic                  i_psum_ready,
    output logic                  o_busy,
    output logic                  o_done
);

    logic start_go;
    logic [1:0] req_valid, grant, rsp_valid;    // 0 ifmap, 1 weight
    pe_data_pkg::gb_req_t [1:0] req;
    pe_data_pkg::gb_rsp_t rsp;
    pe_data_pkg::gb_req_t if_base, w_base;
    logic [pe_cfg_pkg::fill_w-1:0] if_fill, w_fill;

    logic if_valid, if_ready, wt_valid, wt_ready;
    pe_data_pkg::if_pix_t if_head;
    pe_data_pkg::wt_t     wt_head;

    assign start_go     = i_start && !o_busy;
    assign if_base.addr = i_cfg.if_base;
    assign w_base.addr  = i_cfg.w_base;
    assign if_fill      = i_cfg.taps * i_cfg.outs;
    assign w_fill       = pe_cfg_pkg::fill_w'(i_cfg.taps);

    gbuf_shared u_gbuf (
        .i_clk, .i_rstn,
        .i_wr_en(i_gb_wr_en), .i_wr(i_gb_wr),
        .i_req_valid(req_valid), .i_req(req),
        .o_grant(grant), .o_rsp_valid(rsp_valid), .o_rsp(rsp)
    );

    spad_fetch #(.payload_t(pe_data_pkg::if_pix_t), .REPLAY(1'b0)) u_if_pad (
        .i_clk, .i_rstn, .i_start(start_go),
        .i_base(if_base), .i_fill(if_fill), .i_replay_len(i_cfg.taps),
        .o_req_valid(req_valid[0]), .o_req(req[0]), .i_grant(grant[0]),
        .i_rsp_valid(rsp_valid[0]), .i_rsp(rsp),
        .o_valid(if_valid), .o_head(if_head), .i_ready(if_ready)
    );

    spad_fetch #(.payload_t(pe_data_pkg::wt_t), .REPLAY(1'b1)) u_w_pad (
        .i_clk, .i_rstn, .i_start(start_go),
        .i_base(w_base), .i_fill(w_fill), .i_replay_len(i_cfg.taps),
        .o_req_valid(req_valid[1]), .o_req(req[1]), .i_grant(grant[1]),
        .i_rsp_valid(rsp_valid[1]), .i_rsp(rsp),
        .o_valid(wt_valid), .o_head(wt_head), .i_ready(wt_ready)
    );

    pe_mac u_mac (
        .i_clk, .i_rstn, .i_start(start_go),
        .i_taps(i_cfg.taps), .i_outs(i_cfg.outs),
        .i_if_valid(if_valid), .i_if(if_head), .o_if_ready(if_ready),
        .i_wt_valid(wt_valid), .i_wt(wt_head), .o_wt_ready(wt_ready),
        .o_psum_valid, .o_psum, .i_psum_ready,
        .o_busy, .o_done
    );

endmodule

//--- hdl/pe_mac.sv
// ==============================
// one pixel and one weight per cycle, both taken together
// a pending psum blocks further taps until accepted
// ==============================
`timescale 1ns/1ps

module pe_mac (
    input  logic                          i_clk,
    input  logic                          i_rstn,
    input  logic                          i_start,
    input  logic [pe_cfg_pkg::tap_w-1:0]  i_taps,
    input  logic [pe_cfg_pkg::out_w-1:0]  i_outs,
    input  logic                          i_if_valid,
    input  pe_data_pkg::if_pix_t          i_if,
    output logic                          o_if_ready,
    input  logic                          i_wt_valid,
    input  pe_data_pkg::wt_t              i_wt,
    output logic                          o_wt_ready,
    output logic                          o_psum_valid,
    output pe_data_pkg::psum_t            o_psum,
    input  logic                          i_psum_ready,
    output logic                          o_busy,
    output logic                          o_done
);

    logic [pe_cfg_pkg::tap_w-1:0] taps_q, tap_cnt;
    logic [pe_cfg_pkg::out_w-1:0] outs_q, out_cnt;   // out_cnt counts psums produced
    pe_data_pkg::psum_t acc_q, acc_nxt, prod_ext;
    logic signed [pe_data_pkg::pix_w+pe_data_pkg::wt_w-1:0] prod;

    logic take, mac_en, last_tap, accept;

    assign take       = o_busy && !o_psum_valid && i_if_valid && i_wt_valid;
    assign o_if_ready = take;
    assign o_wt_ready = take;
    assign mac_en     = take && !i_if.zero;     // zero pixel skips the multiply

    assign prod     = mac_en ? $signed(i_if.data) * i_wt : 'sd0;    // both arms signed
    assign prod_ext = prod;                     // sign extended
    assign acc_nxt  = ((tap_cnt == '0) ? '0 : acc_q) + prod_ext;
    assign last_tap = (tap_cnt == taps_q - 1'b1);
    assign accept   = o_psum_valid && i_psum_ready;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            taps_q       <= '0;
            outs_q       <= '0;
            tap_cnt      <= '0;
            out_cnt      <= '0;
            acc_q        <= '0;
            o_psum       <= '0;
            o_psum_valid <= 1'b0;
            o_busy       <= 1'b0;
            o_done       <= 1'b0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                taps_q       <= i_taps;
                outs_q       <= i_outs;
                tap_cnt      <= '0;
                out_cnt      <= '0;
                o_psum_valid <= 1'b0;
                o_busy       <= 1'b1;
            end else begin
                if (take) begin
                    acc_q <= acc_nxt;
                    if (last_tap) begin
                        o_psum       <= acc_nxt;    // window closed
                        o_psum_valid <= 1'b1;
                        tap_cnt      <= '0;
                        out_cnt      <= out_cnt + 1'b1;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                if (accept) begin
                    o_psum_valid <= 1'b0;
                    if (out_cnt == outs_q) begin
                        o_busy <= 1'b0;
                        o_done <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- hdl/spad_fetch.sv
// ==============================
// pad of pad_depth entries, refilled from the global buffer
// REPLAY=1 expects i_fill equal to i_replay_len and keeps every entry
// ==============================
`timescale 1ns/1ps

module spad_fetch #(
    parameter type payload_t = pe_data_pkg::if_pix_t,
    parameter bit  REPLAY    = 1'b0
) (
    input  logic                                          i_clk,
    input  logic                                          i_rstn,
    input  logic                                          i_start,
    input  pe_data_pkg::gb_req_t                          i_base,
    input  logic [pe_cfg_pkg::out_w+pe_cfg_pkg::tap_w-1:0] i_fill,
    input  logic [pe_cfg_pkg::tap_w-1:0]                  i_replay_len,
    output logic                                          o_req_valid,
    output pe_data_pkg::gb_req_t                          o_req,
    input  logic                                          i_grant,
    input  logic                                          i_rsp_valid,
    input  pe_data_pkg::gb_rsp_t                          i_rsp,
    output logic                                          o_valid,
    output payload_t                                      o_head,
    input  logic                                          i_ready
);

    payload_t pad_mem [pe_cfg_pkg::pad_depth];
    payload_t wr_word;

    pe_cfg_pkg::fill_t    rem_q;        // words still to request
    pe_data_pkg::gb_req_t addr_q;
    pe_cfg_pkg::pad_ptr_t free_q;       // entries not yet reserved
    pe_cfg_pkg::pad_ptr_t occ_q;        // entries written
    pe_cfg_pkg::pad_ptr_t wr_ptr_q;
    pe_cfg_pkg::pad_ptr_t rd_ptr_q;
    pe_cfg_pkg::pad_ptr_t rd_lim;
    logic [pe_cfg_pkg::tap_w-1:0] len_q;

    logic xfer;
    logic free_ret;

    // ==============================
    // response to payload
    // ==============================
    generate
        if ($bits(payload_t) == pe_data_pkg::pix_w + 1) begin : g_zero
            assign wr_word = payload_t'({i_rsp.data, i_rsp.data == '0});
        end else begin : g_plain
            assign wr_word = payload_t'(i_rsp.data[$bits(payload_t)-1:0]);  // low bits only
        end
    endgenerate

    // requests only when a slot is reserved for the answer
    assign o_req_valid = (rem_q != '0) && (free_q != '0);
    assign o_req       = addr_q;

    assign o_valid  = REPLAY ? (occ_q > rd_ptr_q) : (occ_q != '0);
    assign o_head   = pad_mem[rd_ptr_q];
    assign xfer     = o_valid && i_ready;
    assign free_ret = xfer && !REPLAY;      // replayed entries stay put

    assign rd_lim = REPLAY ? pe_cfg_pkg::pad_ptr_t'(len_q - 1'b1)
                           : pe_cfg_pkg::pad_ptr_t'(pe_cfg_pkg::pad_depth - 1);

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            rem_q    <= '0;
            addr_q   <= '0;
            free_q   <= '0;
            occ_q    <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            len_q    <= '0;
        end else if (i_start) begin
            rem_q    <= i_fill;
            addr_q   <= i_base;
            free_q   <= pe_cfg_pkg::pad_ptr_t'(pe_cfg_pkg::pad_depth);
            occ_q    <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            len_q    <= i_replay_len;
        end else begin
            if (i_grant) begin
                rem_q       <= rem_q - 1'b1;
                addr_q.addr <= addr_q.addr + 1'b1;
            end
            free_q <= free_q - pe_cfg_pkg::pad_ptr_t'(i_grant)
                             + pe_cfg_pkg::pad_ptr_t'(free_ret);
            occ_q  <= occ_q + pe_cfg_pkg::pad_ptr_t'(i_rsp_valid)
                            - pe_cfg_pkg::pad_ptr_t'(free_ret);
            if (i_rsp_valid) begin
                wr_ptr_q <= (wr_ptr_q == pe_cfg_pkg::pad_ptr_t'(pe_cfg_pkg::pad_depth - 1))
                            ? '0 : wr_ptr_q + 1'b1;
            end
            if (xfer) begin
                rd_ptr_q <= (rd_ptr_q == rd_lim) ? '0 : rd_ptr_q + 1'b1;
            end
        end
    end

    // entry storage
    always_ff @(posedge i_clk) begin
        if (i_rsp_valid) begin
            pad_mem[wr_ptr_q] <= wr_word;
        end
    end

endmodule

//--- hdl/gbuf_shared.sv
// ==============================
// one read per cycle shared by two pads, response 1 cycle after grant
// writes and reads to the same word in one cycle return the old word
// ==============================
`timescale 1ns/1ps

module gbuf_shared (
    input  logic                                i_clk,
    input  logic                                i_rstn,
    input  logic                                i_wr_en,
    input  pe_data_pkg::gb_wr_t                 i_wr,
    input  logic [1:0]                          i_req_valid,
    input  pe_data_pkg::gb_req_t [1:0]          i_req,
    output logic [1:0]                          o_grant,
    output logic [1:0]                          o_rsp_valid,
    output pe_data_pkg::gb_rsp_t                o_rsp
);

    logic [pe_data_pkg::pix_w-1:0] mem [pe_cfg_pkg::gb_depth];
    logic [pe_data_pkg::pix_w-1:0] rd_q;

    logic last_q;   // index of the last winner
    logic win;
    logic any_grant;

    // ==============================
    // round-robin arbiter
    // ==============================
    always_comb begin
        if (i_req_valid == 2'b11) begin
            // both asking, last winner waits
            o_grant = last_q ? 2'b01 : 2'b10;
        end else begin
            o_grant = i_req_valid;
        end
    end

    assign win       = o_grant[1];
    assign any_grant = |o_grant;

    always_ff @(posedge i_clk or negedge i_rstn) begin
        if (!i_rstn) begin
            last_q      <= 1'b0;
            o_rsp_valid <= 2'b00;
        end else begin
            o_rsp_valid <= o_grant;     // follows the grant by one cycle
            if (any_grant) begin
                last_q <= win;
            end
        end
    end

    // ==============================
    // memory
    // ==============================
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr.addr] <= i_wr.data;    // external load
        end
        if (any_grant) begin
            rd_q <= mem[i_req[win].addr];
        end
    end

    assign o_rsp.data = rd_q;

endmodule

//--- hdl/pe_data_pkg.sv
// ==============================
// payloads between buffer, pads and MAC
// weights take the low byte of a buffer word
// ==============================

package pe_data_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int pix_w  = 16;
    localparam int wt_w   = 8;
    localparam int psum_w = 32;

    // ==============================
    // pad heads
    // ==============================
    // zero sits in the lsb, set as the word enters the pad
    typedef struct packed {
        logic signed [pix_w-1:0] data;
        logic                    zero;
    } if_pix_t;

    typedef logic signed [wt_w-1:0]   wt_t;
    typedef logic signed [psum_w-1:0] psum_t;

    // ==============================
    // global buffer ports
    // ==============================
    typedef struct packed {
        logic [pe_cfg_pkg::gb_aw-1:0] addr;
        logic [pix_w-1:0]             data;
    } gb_wr_t;

    typedef struct packed {
        logic [pe_cfg_pkg::gb_aw-1:0] addr;
    } gb_req_t;

    typedef struct packed {
        logic [pix_w-1:0] data;
    } gb_rsp_t;

endpackage

//--- hdl/pe_cfg_pkg.sv
// ==============================
// run sizes for one PE slice. taps must be 1..pad_depth and outs at least 1
// ==============================

package pe_cfg_pkg;

    // ==============================
    // global buffer
    // ==============================
    localparam int gb_aw    = 8;            // 256 words
    localparam int gb_depth = 1 << gb_aw;

    // ==============================
    // scratch pads
    // ==============================
    localparam int pad_depth = 12;
    localparam int pad_aw    = $clog2(pad_depth + 1);  // holds pointers and counts up to 12

    typedef logic [pad_aw-1:0] pad_ptr_t;

    // ==============================
    // run counters
    // ==============================
    localparam int tap_w  = 4;              // taps per window
    localparam int out_w  = 6;              // windows per run
    localparam int fill_w = out_w + tap_w;  // ifmap words per run

    typedef logic [fill_w-1:0] fill_t;

    // run configuration, latched on start
    typedef struct packed {
        logic [gb_aw-1:0] if_base;  // first ifmap word
        logic [gb_aw-1:0] w_base;   // first weight word
        logic [tap_w-1:0] taps;     // filter row length
        logic [out_w-1:0] outs;     // psums per run
    } pe_cfg_t;

endpackage
